// ==== verilog/parser_pkg.sv ====
//----------------------------------------------------------------------
// Shared widths, types and unit count for the header field extraction
// core. Every design file imports this package for its port types.
// The chain length and field size are set here for all modules.
//----------------------------------------------------------------------

package parser_pkg;

    // Chain size and field limits
    localparam int NUM_UNITS   = 4;
    localparam int FIELD_BYTES = 4;
    localparam int BYTE_W      = 8;
    localparam int OFFSET_W    = 8;
    localparam int LEN_W       = 3;
    localparam int FIELD_W     = BYTE_W * FIELD_BYTES;

    // Configuration port
    localparam int CFG_ADDR_W = 3;
    localparam int CFG_DATA_W = 8;
    localparam int ACTION_W   = 2 + LEN_W;

    typedef logic [OFFSET_W-1:0]   offset_t;
    typedef logic [LEN_W-1:0]      len_t;
    typedef logic [FIELD_W-1:0]    field_t;
    typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

    // One action entry per extraction unit
    typedef struct packed {
        logic enable;
        logic lookup;
        len_t len;
    } action_t;

    // Addresses 0 .. NUM_UNITS-1 hold the unit entries
    localparam cfg_addr_t CFG_ADDR_START = 3'd4;

endpackage

// ==== verilog/parser_cfg_regs.sv ====
//----------------------------------------------------------------------
// Configuration registers for the extraction chain. Holds the global
// start offset and one action entry per unit. Written through a
// four-phase req/ack port, only between headers.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module parser_cfg_regs (
    input  logic                                           clk,
    input  logic                                           rst_i,
    input  logic                                           cfg_req_i,
    input  parser_pkg::cfg_addr_t                          cfg_addr_i,
    input  logic [parser_pkg::CFG_DATA_W-1:0]              cfg_data_i,
    output logic                                           cfg_ack_o,
    output parser_pkg::action_t [parser_pkg::NUM_UNITS-1:0] actions_o,
    output parser_pkg::offset_t                            start_offset_o
);

    import parser_pkg::*;

    //------------------------------------------------------------------
    // Slave side of the write handshake
    //------------------------------------------------------------------

    // Write happens once per request, on the edge that raises ack
    always_ff @(posedge clk) begin
        if (rst_i) begin
            actions_o      <= '0;
            start_offset_o <= '0;
            cfg_ack_o      <= 1'b0;
        end else begin
            if (cfg_req_i && !cfg_ack_o) begin
                for (int u = 0; u < NUM_UNITS; u++) begin
                    if (cfg_addr_i == cfg_addr_t'(u)) begin
                        actions_o[u] <= cfg_data_i[ACTION_W-1:0];
                    end
                end
                if (cfg_addr_i == CFG_ADDR_START) begin
                    start_offset_o <= cfg_data_i;
                end
                // Unmapped addresses still get an ack
                cfg_ack_o <= 1'b1;
            end else if (!cfg_req_i && cfg_ack_o) begin
                cfg_ack_o <= 1'b0;
            end
        end
    end

endmodule

// ==== verilog/parser_hdr_ctrl.sv ====
//----------------------------------------------------------------------
// Header input control. Accepts one byte per cycle, numbers the bytes
// of a header and flags its first byte for the units. Offers the
// result over a four-phase req/ack port and holds the source until
// the handshake has fully returned to idle.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module parser_hdr_ctrl (
    input  logic                              clk,
    input  logic                              rst_i,
    input  logic                              hdr_valid_i,
    input  logic [parser_pkg::BYTE_W-1:0]     hdr_byte_i,
    input  logic                              hdr_last_i,
    input  logic                              res_ack_i,
    output logic                              byte_en_o,
    output logic [parser_pkg::BYTE_W-1:0]     byte_o,
    output parser_pkg::offset_t               byte_idx_o,
    output logic                              hdr_start_o,
    output logic                              res_req_o,
    output logic                              hold_o
);

    import parser_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_OFFER,
        ST_WAIT_LOW
    } res_state_t;

    res_state_t state_q;
    offset_t    idx_q;
    logic       accept;

    //------------------------------------------------------------------
    // Byte acceptance and indexing
    //------------------------------------------------------------------

    assign accept      = hdr_valid_i && !hold_o;
    assign byte_en_o   = accept;
    assign byte_o      = hdr_byte_i;
    assign byte_idx_o  = idx_q;
    assign hdr_start_o = accept && (idx_q == '0);

    // Index restarts after the last byte of a header
    always_ff @(posedge clk) begin
        if (rst_i) begin
            idx_q <= '0;
        end else if (accept) begin
            idx_q <= hdr_last_i ? '0 : idx_q + 1'b1;
        end
    end

    //------------------------------------------------------------------
    // Result handshake
    //------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:     if (accept && hdr_last_i) state_q <= ST_OFFER;
                ST_OFFER:    if (res_ack_i) state_q <= ST_WAIT_LOW;
                ST_WAIT_LOW: if (!res_ack_i) state_q <= ST_IDLE;
                default:     state_q <= ST_IDLE;
            endcase
        end
    end

    assign res_req_o = (state_q == ST_OFFER);
    // Fields must not move while the result is pending
    assign hold_o    = (state_q != ST_IDLE);

endmodule

// ==== verilog/parser_ext_unit.sv ====
//----------------------------------------------------------------------
// One field extraction unit. Its window starts where the previous
// unit finished and spans the configured length. Bytes in the window
// shift into the field register. The lookup key passes down the
// chain, or is taken from this field when the unit is flagged.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module parser_ext_unit (
    input  logic                              clk,
    input  logic                              rst_i,
    input  parser_pkg::action_t               action_i,
    input  parser_pkg::offset_t               start_offset_i,
    output parser_pkg::offset_t               finish_offset_o,
    input  logic                              byte_en_i,
    input  logic [parser_pkg::BYTE_W-1:0]     byte_i,
    input  parser_pkg::offset_t               byte_idx_i,
    input  logic                              hdr_start_i,
    output parser_pkg::field_t                field_o,
    input  parser_pkg::field_t                lookup_i,
    input  logic                              lookup_valid_i,
    output parser_pkg::field_t                lookup_o,
    output logic                              lookup_valid_o
);

    import parser_pkg::*;

    offset_t finish;
    logic    in_window;
    logic    own_key;
    field_t  field_q;
    field_t  field_base;

    //------------------------------------------------------------------
    // Offset chaining
    //------------------------------------------------------------------

    // Disabled unit takes no bytes
    assign finish = action_i.enable ? start_offset_i + offset_t'(action_i.len)
                                    : start_offset_i;
    assign finish_offset_o = finish;

    assign in_window = (byte_idx_i >= start_offset_i) && (byte_idx_i < finish);

    //------------------------------------------------------------------
    // Field capture
    //------------------------------------------------------------------

    // First byte of a header starts from an empty field
    assign field_base = hdr_start_i ? '0 : field_q;

    // First byte ends up most significant
    always_ff @(posedge clk) begin
        if (rst_i) begin
            field_q <= '0;
        end else if (byte_en_i) begin
            if (in_window) begin
                field_q <= {field_base[FIELD_W-BYTE_W-1:0], byte_i};
            end else begin
                field_q <= field_base;
            end
        end
    end

    assign field_o = field_q;

    //------------------------------------------------------------------
    // Lookup pass-along
    //------------------------------------------------------------------

    // Earlier units in the chain win
    assign own_key        = action_i.enable && action_i.lookup;
    assign lookup_valid_o = lookup_valid_i || own_key;
    assign lookup_o       = lookup_valid_i ? lookup_i
                          : (own_key ? field_q : '0);

endmodule

// ==== verilog/parser_ext_core.sv ====
//----------------------------------------------------------------------
// Top level of the header field extraction core. Connects the
// configuration registers, the header control and a chain of
// extraction units. The last unit's finish offset and lookup key,
// together with all fields, form the result.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module parser_ext_core (
    input  logic                                          clk,
    input  logic                                          rst_i,

    // Configuration port
    input  logic                                          cfg_req_i,
    input  parser_pkg::cfg_addr_t                         cfg_addr_i,
    input  logic [parser_pkg::CFG_DATA_W-1:0]             cfg_data_i,
    output logic                                          cfg_ack_o,

    // Header input
    input  logic                                          hdr_valid_i,
    input  logic [parser_pkg::BYTE_W-1:0]                 hdr_byte_i,
    input  logic                                          hdr_last_i,
    output logic                                          hold_o,

    // Result port
    output logic                                          res_req_o,
    input  logic                                          res_ack_i,
    output parser_pkg::field_t [parser_pkg::NUM_UNITS-1:0] fields_o,
    output parser_pkg::offset_t                           finish_offset_o,
    output parser_pkg::field_t                            lookup_key_o,
    output logic                                          lookup_valid_o
);

    import parser_pkg::*;

    action_t [NUM_UNITS-1:0] actions;

    logic                byte_en;
    logic [BYTE_W-1:0]   byte_data;
    offset_t             byte_idx;
    logic                hdr_start;

    // Entry 0 of each chain link feeds the first unit
    offset_t             chain_off [0:NUM_UNITS];
    field_t              chain_key [0:NUM_UNITS];
    logic                chain_kv  [0:NUM_UNITS];

    parser_cfg_regs u_cfg_regs (
        .clk            (clk),
        .rst_i          (rst_i),
        .cfg_req_i      (cfg_req_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_ack_o      (cfg_ack_o),
        .actions_o      (actions),
        .start_offset_o (chain_off[0])
    );

    parser_hdr_ctrl u_hdr_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .hdr_valid_i    (hdr_valid_i),
        .hdr_byte_i     (hdr_byte_i),
        .hdr_last_i     (hdr_last_i),
        .res_ack_i      (res_ack_i),
        .byte_en_o      (byte_en),
        .byte_o         (byte_data),
        .byte_idx_o     (byte_idx),
        .hdr_start_o    (hdr_start),
        .res_req_o      (res_req_o),
        .hold_o         (hold_o)
    );

    // No key enters the head of the chain
    assign chain_key[0] = '0;
    assign chain_kv[0]  = 1'b0;

    for (genvar i = 0; i < NUM_UNITS; i++) begin : g_unit
        parser_ext_unit u_unit (
            .clk             (clk),
            .rst_i           (rst_i),
            .action_i        (actions[i]),
            .start_offset_i  (chain_off[i]),
            .finish_offset_o (chain_off[i+1]),
            .byte_en_i       (byte_en),
            .byte_i          (byte_data),
            .byte_idx_i      (byte_idx),
            .hdr_start_i     (hdr_start),
            .field_o         (fields_o[i]),
            .lookup_i        (chain_key[i]),
            .lookup_valid_i  (chain_kv[i]),
            .lookup_o        (chain_key[i+1]),
            .lookup_valid_o  (chain_kv[i+1])
        );
    end

    assign finish_offset_o = chain_off[NUM_UNITS];
    assign lookup_key_o    = chain_key[NUM_UNITS];
    assign lookup_valid_o  = chain_kv[NUM_UNITS];

endmodule

// ==== sim/parser_ext_assertions.sv ====
//----------------------------------------------------------------------
// Handshake and result stability checks for the extraction core.
// Bound to the top level by the testbench, which reads the count of
// failed checks at the end of the run.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module parser_ext_assertions (
    input logic                                           clk,
    input logic                                           rst_i,
    input logic                                           cfg_req_i,
    input logic                                           cfg_ack_o,
    input logic                                           hdr_valid_i,
    input logic                                           hold_o,
    input logic                                           res_req_o,
    input logic                                           res_ack_i,
    input parser_pkg::field_t [parser_pkg::NUM_UNITS-1:0] fields_o,
    input parser_pkg::offset_t                            finish_offset_o,
    input parser_pkg::field_t                             lookup_key_o,
    input logic                                           lookup_valid_o
);

    // Number of failed checks
    int fail_count = 0;

    // Configuration ack follows the request level
    a_cfg_ack_rise: assert property (@(posedge clk) disable iff (rst_i)
        $rose(cfg_ack_o) |-> $past(cfg_req_i))
        else begin
            fail_count++;
            $error("cfg_ack_o rose while cfg_req_i was low");
        end

    a_cfg_ack_fall: assert property (@(posedge clk) disable iff (rst_i)
        $fell(cfg_ack_o) |-> !$past(cfg_req_i))
        else begin
            fail_count++;
            $error("cfg_ack_o fell while cfg_req_i was high");
        end

    // Offered result holds until acknowledged
    a_res_stable: assert property (@(posedge clk) disable iff (rst_i)
        res_req_o && !res_ack_i |=> res_req_o && $stable(fields_o)
            && $stable(finish_offset_o) && $stable(lookup_key_o)
            && $stable(lookup_valid_o))
        else begin
            fail_count++;
            $error("result changed or res_req_o dropped before res_ack_i");
        end

    a_no_valid_on_hold: assert property (@(posedge clk) disable iff (rst_i)
        hold_o |-> !hdr_valid_i)
        else begin
            fail_count++;
            $error("hdr_valid_i driven while hold_o is high");
        end

endmodule

// ==== sim/tb_parser_ext_core.sv ====
//----------------------------------------------------------------------
// Testbench for the header field extraction core. Writes the unit
// configuration, streams directed and random headers, and compares
// each offered result with a reference model of the chain.
//----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_parser_ext_core;

    import parser_pkg::*;

    localparam int PERIOD_NS   = 100;
    localparam int MAX_HDR     = 24;
    localparam int NUM_RANDOM  = 24;
    localparam int NUM_TESTS   = NUM_RANDOM + 4;
    localparam int TEST_MARGIN = 60;
    localparam int WAIT_LIMIT  = 64;
    localparam int WATCHDOG_NS = (NUM_TESTS * (MAX_HDR + TEST_MARGIN) + 16) * PERIOD_NS;

    logic                    clk = 1'b0;
    logic                    rst_i;
    logic                    cfg_req_i;
    cfg_addr_t               cfg_addr_i;
    logic [CFG_DATA_W-1:0]   cfg_data_i;
    logic                    cfg_ack_o;
    logic                    hdr_valid_i;
    logic [BYTE_W-1:0]       hdr_byte_i;
    logic                    hdr_last_i;
    logic                    hold_o;
    logic                    res_req_o;
    logic                    res_ack_i;
    field_t [NUM_UNITS-1:0]  fields_o;
    offset_t                 finish_offset_o;
    field_t                  lookup_key_o;
    logic                    lookup_valid_o;

    // Current stimulus and expected result
    action_t [NUM_UNITS-1:0] cur_acts;
    logic [BYTE_W-1:0]       hdr_buf [0:MAX_HDR-1];
    field_t [NUM_UNITS-1:0]  exp_fields;
    offset_t                 exp_fin;
    field_t                  exp_key;
    logic                    exp_kv;
    logic                    req_seen = 1'b0;
    int                      err_count = 0;
    int                      test_count = 0;

    parser_ext_core DUT (.*);

    bind parser_ext_core parser_ext_assertions u_assertions (
        .clk             (clk),
        .rst_i           (rst_i),
        .cfg_req_i       (cfg_req_i),
        .cfg_ack_o       (cfg_ack_o),
        .hdr_valid_i     (hdr_valid_i),
        .hold_o          (hold_o),
        .res_req_o       (res_req_o),
        .res_ack_i       (res_ack_i),
        .fields_o        (fields_o),
        .finish_offset_o (finish_offset_o),
        .lookup_key_o    (lookup_key_o),
        .lookup_valid_o  (lookup_valid_o)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    //------------------------------------------------------------------
    // Reference model and compare tasks
    //------------------------------------------------------------------

    function automatic action_t make_action(input logic en, input logic lk, input int ln);
        return '{enable: en, lookup: lk, len: len_t'(ln)};
    endfunction

    // Enabled units take len bytes and a short header cuts fields
    function automatic void ref_extract(input action_t [NUM_UNITS-1:0] acts,
                                        input offset_t start, input int hdr_len,
                                        output field_t [NUM_UNITS-1:0] flds,
                                        output offset_t fin, output field_t key,
                                        output logic kv);
        int pos;
        pos = int'(start);
        key = '0;
        kv  = 1'b0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            flds[u] = '0;
            if (acts[u].enable) begin
                for (int b = 0; b < int'(acts[u].len); b++) begin
                    if (pos + b < hdr_len) begin
                        flds[u] = {flds[u][FIELD_W-BYTE_W-1:0], hdr_buf[pos + b]};
                    end
                end
                pos = pos + int'(acts[u].len);
                if (acts[u].lookup && !kv) begin
                    key = flds[u];
                    kv  = 1'b1;
                end
            end
        end
        fin = offset_t'(pos);
    endfunction

    // Value mismatches plus failed assertions
    function automatic int total_errors();
        return err_count + DUT.u_assertions.fail_count;
    endfunction

    task automatic check_field(input int u, input field_t got, input field_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: field %0d is %h, expected %h", $time, u, got, exp);
        end
    endtask

    task automatic check_offset(input offset_t got, input offset_t exp);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: finish offset is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_lookup(input field_t got_key, input logic got_v,
                                input field_t exp_k, input logic exp_v);
        if (got_v !== exp_v || got_key !== exp_k) begin
            err_count++;
            $display("[ERROR] %0t: lookup is %h/%b, expected %h/%b",
                     $time, got_key, got_v, exp_k, exp_v);
        end
    endtask

    // Compare on every rise of the result request
    always @(negedge clk) begin
        if (res_req_o && !req_seen) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                check_field(u, fields_o[u], exp_fields[u]);
            end
            check_offset(finish_offset_o, exp_fin);
            check_lookup(lookup_key_o, lookup_valid_o, exp_key, exp_kv);
        end
        req_seen = res_req_o;
    end

    //------------------------------------------------------------------
    // Handshake and stimulus tasks
    //------------------------------------------------------------------

    task automatic abort_run(input string msg);
        err_count++;
        $display("%s at %0t", msg, $time);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic wait_until(input string name, input logic level);
        logic v;
        for (int n = 0; n < WAIT_LIMIT; n++) begin
            @(negedge clk);
            if (name == "cfg_ack") v = cfg_ack_o;
            else if (name == "res_req") v = res_req_o;
            else v = hold_o;
            if (v == level) return;
        end
        abort_run({name, " never reached the expected level"});
    endtask

    task automatic cfg_write(input cfg_addr_t addr, input logic [CFG_DATA_W-1:0] data);
        @(posedge clk);
        cfg_req_i  <= 1'b1;
        cfg_addr_i <= addr;
        cfg_data_i <= data;
        wait_until("cfg_ack", 1'b1);
        @(posedge clk);
        cfg_req_i <= 1'b0;
        wait_until("cfg_ack", 1'b0);
    endtask

    task automatic run_test(input offset_t start, input int hdr_len);
        int errs_before;
        int delay;
        errs_before = total_errors();
        for (int u = 0; u < NUM_UNITS; u++) begin
            cfg_write(cfg_addr_t'(u), {3'b000, cur_acts[u]});
        end
        cfg_write(CFG_ADDR_START, start);
        for (int i = 0; i < hdr_len; i++) begin
            hdr_buf[i] = 8'($urandom);
        end
        ref_extract(cur_acts, start, hdr_len, exp_fields, exp_fin, exp_key, exp_kv);
        for (int i = 0; i < hdr_len; i++) begin
            @(posedge clk);
            hdr_valid_i <= 1'b1;
            hdr_byte_i  <= hdr_buf[i];
            hdr_last_i  <= (i == hdr_len - 1);
        end
        @(posedge clk);
        hdr_valid_i <= 1'b0;
        hdr_last_i  <= 1'b0;
        wait_until("res_req", 1'b1);
        // Result and hold must not move before a late ack
        delay = $urandom_range(0, 5);
        repeat (delay) begin
            @(negedge clk);
            if (!hold_o || !res_req_o) begin
                err_count++;
                $display("hold or request dropped before the ack at %0t", $time);
            end
            for (int u = 0; u < NUM_UNITS; u++) begin
                check_field(u, fields_o[u], exp_fields[u]);
            end
        end
        @(posedge clk);
        res_ack_i <= 1'b1;
        wait_until("res_req", 1'b0);
        @(posedge clk);
        res_ack_i <= 1'b0;
        wait_until("hold", 1'b0);
        $display("test %0d (start %0d, %0d bytes): %s", test_count, start, hdr_len,
                 (total_errors() == errs_before) ? "ok" : "mismatch");
        test_count++;
    endtask

    //------------------------------------------------------------------
    // Main sequence and watchdog
    //------------------------------------------------------------------

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        void'($urandom(44538));
        rst_i       = 1'b1;
        cfg_req_i   = 1'b0;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        hdr_valid_i = 1'b0;
        hdr_byte_i  = '0;
        hdr_last_i  = 1'b0;
        res_ack_i   = 1'b0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;

        // Contiguous fields with the key from unit 2
        cur_acts = {make_action(1, 0, 4), make_action(1, 1, 3),
                    make_action(1, 0, 2), make_action(1, 0, 1)};
        run_test(8'd2, 16);
        // Unit 1 disabled with its flag ignored
        cur_acts = {make_action(1, 1, 4), make_action(1, 0, 1),
                    make_action(0, 1, 3), make_action(1, 0, 2)};
        run_test(8'd0, 20);
        // No flagged unit
        cur_acts = {make_action(1, 0, 2), make_action(1, 0, 4),
                    make_action(1, 0, 3), make_action(1, 0, 1)};
        run_test(8'd5, 24);
        // Header ends inside unit 1
        cur_acts = {make_action(1, 0, 4), make_action(1, 1, 4),
                    make_action(1, 1, 4), make_action(1, 0, 4)};
        run_test(8'd3, 9);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                cur_acts[u] = make_action($urandom_range(0, 3) != 0,
                                          $urandom_range(0, 2) == 0,
                                          $urandom_range(0, 4));
            end
            run_test(offset_t'($urandom_range(0, 7)), $urandom_range(1, MAX_HDR));
        end

        $display("%0d tests run, %0d errors", test_count, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/parser_pkg.sv
verilog/parser_cfg_regs.sv
verilog/parser_hdr_ctrl.sv
verilog/parser_ext_unit.sv
verilog/parser_ext_core.sv
sim/parser_ext_assertions.sv
sim/tb_parser_ext_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the extraction core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_parser_ext_core \
    --Mdir obj_dir -o tb_sim \
    -f sources.f

./obj_dir/tb_sim | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
